/* Makefile */
# Verilator build and run for the issue-arbitration front end

VERILATOR ?= verilator
TOP       ?= tb_chp_issue
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
STIM      ?= chp_issue_stim.txt
VFLAGS    ?= --binary --timing --assert

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SRCS    := $(shell grep -v '^+' $(FILELIST)) chp_defines.svh

.PHONY: all run clean

all: run

# rebuilt only when a source, the header or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the log decides the result, not the exit status of the simulator
run: $(SIM_BIN) $(STIM)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx '\*\* PASS \*\*' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
+incdir+.
chp_pkg.sv
chp_rr_arb_windex.sv
chp_class_arb.sv
chp_issue_arb.sv
chp_issue_sel.sv
chp_issue_top.sv
tb_chp_issue.sv

/* chp_class_arb.sv */
/*
  Per-class queue arbiter for one bank of request bits.
  The round-robin pointer lives here and only moves on update.
  update must only be raised for a cycle in which this class has a winner.
  qid is combinational from req and the current pointer.
*/

`timescale 1ns/1ps

`include "chp_defines.svh"

module chp_class_arb (
    input  logic                       hqm_gated_clk
  , input  logic                       hqm_gated_rst_b
  , input  logic [`CHP_NUM_QUEUES-1:0] req
  , input  logic                       update
  , output logic                       winner_v
  , output logic [`CHP_QID_W-1:0]      qid
);

  // highest queue number, the pointer wraps to zero after it
  localparam int LAST_Q = `CHP_NUM_QUEUES - 1;

  logic [`CHP_QID_W-1:0] ptr_f;
  logic [`CHP_QID_W-1:0] ptr_nxt;

  // --------------------------------------------------
  // queue pick
  // --------------------------------------------------

  // the search starts at the stored pointer
  chp_rr_arb_windex #(
    .NUM_REQS ( `CHP_NUM_QUEUES )
  ) i_queue_arb (
      .reqs     ( req )
    , .index_f  ( ptr_f )
    , .winner_v ( winner_v )
    , .winner   ( qid )
  );

  // --------------------------------------------------
  // pointer
  // --------------------------------------------------

  // the granted queue drops to lowest priority once it is taken
  // without a taken grant the pointer stays where it is
  always_comb begin
    ptr_nxt = ptr_f;
    if (update && winner_v) begin
      if (int'(qid) == LAST_Q) begin
        ptr_nxt = '0;
      end else begin
        ptr_nxt = qid + 1'b1;
      end
    end
  end

  always_ff @(posedge hqm_gated_clk or negedge hqm_gated_rst_b) begin
    if (!hqm_gated_rst_b) begin
      ptr_f <= '0;
    end else begin
      ptr_f <= ptr_nxt;
    end
  end

  // the taken strobe comes from the issue selector and must follow this grant
  a_update_has_winner : assert property (
    @(posedge hqm_gated_clk) disable iff (!hqm_gated_rst_b)
    update |-> winner_v
  ) else $error("class arbiter taken without a winner");

endmodule

/* chp_defines.svh */
/*
  Sizing macros shared by the issue-arbitration front end.
  CHP_QID_W must equal log2 of CHP_NUM_QUEUES, nothing checks the pair.
  CHP_NUM_CLASSES stays at 4 because the set pairing only exists for four classes.
*/

`ifndef CHP_DEFINES_SVH
`define CHP_DEFINES_SVH

// --------------------------------------------------
// queue side
// --------------------------------------------------

// request bits per class, one bit per queue
`define CHP_NUM_QUEUES 8

// width of a queue index carried with each issue slot
`define CHP_QID_W 3

// --------------------------------------------------
// class side
// --------------------------------------------------

// sch_ldb, enq_dir, sch_dir and enq_ldb, in that slot order
`define CHP_NUM_CLASSES 4

`endif

/* chp_issue_arb.sv */
/*
  Class-level issue arbiter with a priority index that knows about dual issue.
  reqs is in chp_class_e slot order, one winner_v per class arbiter.
  winner_dual means the winner and its partner both issue this cycle.
  The index only moves when winner_v and update are both high.
*/

`timescale 1ns/1ps

`include "chp_defines.svh"

module chp_issue_arb import chp_pkg::*; (
    input  logic                        hqm_gated_clk
  , input  logic                        hqm_gated_rst_b
  , input  logic [`CHP_NUM_CLASSES-1:0] reqs
  , input  logic                        update
  , output logic                        winner_v
  , output logic [1:0]                  winner
  , input  logic                        winner_dual
);

  logic [1:0] index_f;
  logic [1:0] index_nxt;

  // cyclic class pick from the stored high priority index
  chp_rr_arb_windex #(
    .NUM_REQS ( `CHP_NUM_CLASSES )
  ) i_class_arb (
      .reqs     ( reqs )
    , .index_f  ( index_f )
    , .winner_v ( winner_v )
    , .winner   ( winner )
  );

  // --------------------------------------------------
  // priority index
  // --------------------------------------------------

  // a single issue moves priority just past the winner, the 2 bit add wraps
  // a dual issue used a whole set, so priority jumps to the start of the other set
  always_comb begin
    index_nxt = index_f;
    if (winner_v && update) begin
      if (!winner_dual) begin
        index_nxt = winner + 2'd1;
      end else if (set_of(chp_class_e'(winner)) == CHP_SET_A) begin
        index_nxt = CHP_SCH_DIR;
      end else begin
        index_nxt = CHP_SCH_LDB;
      end
    end
  end

  always_ff @(posedge hqm_gated_clk or negedge hqm_gated_rst_b) begin
    if (!hqm_gated_rst_b) begin
      index_f <= '0;
    end else begin
      index_f <= index_nxt;
    end
  end

  // the selector derives dual from this winner, so it cannot be set without one
  a_dual_has_winner : assert property (
    @(posedge hqm_gated_clk) disable iff (!hqm_gated_rst_b)
    winner_dual |-> winner_v
  ) else $error("dual issue flagged with no class winner");

endmodule

/* chp_issue_sel.sv */
/*
  Pairing logic between the class arbiters and the issue arbiter.
  Slot 0 always carries the class winner. Slot 1 carries its partner on dual issue.
  When a slot is not valid its class and qid read zero.
  hold freezes every pointer but the slots still show the current choice.
*/

`timescale 1ns/1ps

`include "chp_defines.svh"

module chp_issue_sel import chp_pkg::*; (
    input  logic                        hqm_gated_clk
  , input  logic                        hqm_gated_rst_b
  , input  logic [`CHP_NUM_CLASSES-1:0] cls_v
  , input  logic [`CHP_QID_W-1:0]       cls_qid0
  , input  logic [`CHP_QID_W-1:0]       cls_qid1
  , input  logic [`CHP_QID_W-1:0]       cls_qid2
  , input  logic [`CHP_QID_W-1:0]       cls_qid3
  , input  logic                        hold
  , output logic [`CHP_NUM_CLASSES-1:0] cls_taken
  , output logic                        issue0_v
  , output chp_class_e                  issue0_class
  , output logic [`CHP_QID_W-1:0]       issue0_qid
  , output logic                        issue1_v
  , output chp_class_e                  issue1_class
  , output logic [`CHP_QID_W-1:0]       issue1_qid
);

  logic                  win_v;
  logic [1:0]            win;
  chp_class_e            win_cls;
  chp_class_e            partner_cls;
  logic                  dual;
  logic [`CHP_QID_W-1:0] qid_a [`CHP_NUM_CLASSES];

  // queue ids gathered in class slot order so the winner can index them
  assign qid_a[0] = cls_qid0;
  assign qid_a[1] = cls_qid1;
  assign qid_a[2] = cls_qid2;
  assign qid_a[3] = cls_qid3;

  // --------------------------------------------------
  // class pick and pairing
  // --------------------------------------------------

  // back-pressure stops the index, the choice itself is still made
  chp_issue_arb i_issue_arb (
      .hqm_gated_clk   ( hqm_gated_clk )
    , .hqm_gated_rst_b ( hqm_gated_rst_b )
    , .reqs            ( cls_v )
    , .update          ( ~hold )
    , .winner_v        ( win_v )
    , .winner          ( win )
    , .winner_dual     ( dual )
  );

  assign win_cls     = chp_class_e'(win);
  assign partner_cls = partner_of(win_cls);

  // the partner uses the other half of the resources, so it can ride along
  assign dual = win_v & cls_v[partner_cls];

  // --------------------------------------------------
  // issue slots
  // --------------------------------------------------

  assign issue0_v     = win_v;
  assign issue0_class = win_v ? win_cls : CHP_SCH_LDB;
  assign issue0_qid   = win_v ? qid_a[win_cls] : '0;

  assign issue1_v     = dual;
  assign issue1_class = dual ? partner_cls : CHP_SCH_LDB;
  assign issue1_qid   = dual ? qid_a[partner_cls] : '0;

  // each issued class gets its taken strobe so its queue pointer moves on
  // nothing is taken while hold is high
  always_comb begin
    cls_taken = '0;
    for (int c = 0; c < `CHP_NUM_CLASSES; c++) begin
      if (win_v && (int'(win_cls) == c)) begin
        cls_taken[c] = ~hold;
      end
      if (dual && (int'(partner_cls) == c)) begin
        cls_taken[c] = ~hold;
      end
    end
  end

  // slot 1 never issues alone and both slots carry requesting classes of one set
  a_slot1_is_partner : assert property (
    @(posedge hqm_gated_clk) disable iff (!hqm_gated_rst_b)
    issue1_v |-> (issue0_v && cls_v[issue0_class] && cls_v[issue1_class] &&
                  (set_of(issue1_class) == set_of(issue0_class)) &&
                  (issue1_class != issue0_class))
  ) else $error("slot 1 issued without a matching slot 0 partner");

endmodule

/* chp_issue_stim.txt */
# rst_b hold sch_ldb enq_dir sch_dir enq_ldb | i0_v i0_cls i0_qid | i1_v i1_cls i1_qid
# all hex, one line per clock cycle, request banks one bit per queue
# idle after reset, no issue
1 0 00 00 00 00  0 0 0  0 0 0
1 0 00 00 00 00  0 0 0  0 0 0
# single enq_dir request on queue 4
1 0 00 10 00 00  1 1 4  0 0 0
# sch_ldb queue round robin, qid steps 0 to 7 and wraps
1 0 ff 00 00 00  1 0 0  0 0 0
1 0 ff 00 00 00  1 0 1  0 0 0
1 0 ff 00 00 00  1 0 2  0 0 0
1 0 ff 00 00 00  1 0 3  0 0 0
1 0 ff 00 00 00  1 0 4  0 0 0
1 0 ff 00 00 00  1 0 5  0 0 0
1 0 ff 00 00 00  1 0 6  0 0 0
1 0 ff 00 00 00  1 0 7  0 0 0
1 0 ff 00 00 00  1 0 0  0 0 0
# class round robin between sch_ldb and sch_dir, no partners present
1 0 01 00 80 00  1 2 7  0 0 0
1 0 01 00 80 00  1 0 0  0 0 0
1 0 01 00 80 00  1 2 7  0 0 0
1 0 01 00 80 00  1 0 0  0 0 0
# all four classes, dual issue alternates between the sets
1 0 ff ff ff ff  1 1 5  1 0 1
1 0 ff ff ff ff  1 2 0  1 3 0
1 0 ff ff ff ff  1 0 2  1 1 6
1 0 ff ff ff ff  1 2 1  1 3 1
1 0 ff ff ff ff  1 0 3  1 1 7
1 0 ff ff ff ff  1 2 2  1 3 2
# hold freezes the pointers, outputs repeat
1 1 ff ff ff ff  1 0 4  1 1 0
1 1 ff ff ff ff  1 0 4  1 1 0
1 1 ff ff ff ff  1 0 4  1 1 0
1 1 ff ff ff ff  1 0 4  1 1 0
1 0 ff ff ff ff  1 0 4  1 1 0
1 0 ff ff ff ff  1 2 3  1 3 3
1 1 ff 00 00 00  1 0 5  0 0 0
1 1 ff 00 00 00  1 0 5  0 0 0
1 0 ff 00 00 00  1 0 5  0 0 0
1 0 ff 00 00 00  1 0 6  0 0 0
# reset in mid-stream returns every pointer to zero
0 0 ff ff ff ff  1 0 0  1 1 0
0 0 ff ff ff ff  1 0 0  1 1 0
1 0 ff ff ff ff  1 0 0  1 1 0
1 0 ff ff ff ff  1 2 0  1 3 0
1 0 ff ff ff ff  1 0 1  1 1 1
1 0 00 00 00 00  0 0 0  0 0 0

/* chp_issue_top.sv */
/*
  Issue-arbitration front end of the credit and history pipe.
  Requests and hold reach the issue outputs in the same cycle.
  Pointers move on the next rising edge and only while hold is low.
  Request banks are levels, there is no handshake on either side.
*/

`timescale 1ns/1ps

`include "chp_defines.svh"

module chp_issue_top import chp_pkg::*; (
    input  logic                       hqm_gated_clk
  , input  logic                       hqm_gated_rst_b
  , input  logic [`CHP_NUM_QUEUES-1:0] sch_ldb_req
  , input  logic [`CHP_NUM_QUEUES-1:0] enq_dir_req
  , input  logic [`CHP_NUM_QUEUES-1:0] sch_dir_req
  , input  logic [`CHP_NUM_QUEUES-1:0] enq_ldb_req
  , input  logic                       hold
  , output logic                       issue0_v
  , output chp_class_e                 issue0_class
  , output logic [`CHP_QID_W-1:0]      issue0_qid
  , output logic                       issue1_v
  , output chp_class_e                 issue1_class
  , output logic [`CHP_QID_W-1:0]      issue1_qid
);

  // class winners and taken strobes, indexed by chp_class_e
  logic [`CHP_NUM_CLASSES-1:0] cls_v;
  logic [`CHP_NUM_CLASSES-1:0] cls_taken;
  logic [`CHP_QID_W-1:0]       sch_ldb_qid;
  logic [`CHP_QID_W-1:0]       enq_dir_qid;
  logic [`CHP_QID_W-1:0]       sch_dir_qid;
  logic [`CHP_QID_W-1:0]       enq_ldb_qid;

  // --------------------------------------------------
  // per-class queue arbiters
  // --------------------------------------------------

  chp_class_arb i_sch_ldb_arb (
      .hqm_gated_clk   ( hqm_gated_clk )
    , .hqm_gated_rst_b ( hqm_gated_rst_b )
    , .req             ( sch_ldb_req )
    , .update          ( cls_taken[CHP_SCH_LDB] )
    , .winner_v        ( cls_v[CHP_SCH_LDB] )
    , .qid             ( sch_ldb_qid )
  );

  chp_class_arb i_enq_dir_arb (
      .hqm_gated_clk   ( hqm_gated_clk )
    , .hqm_gated_rst_b ( hqm_gated_rst_b )
    , .req             ( enq_dir_req )
    , .update          ( cls_taken[CHP_ENQ_DIR] )
    , .winner_v        ( cls_v[CHP_ENQ_DIR] )
    , .qid             ( enq_dir_qid )
  );

  chp_class_arb i_sch_dir_arb (
      .hqm_gated_clk   ( hqm_gated_clk )
    , .hqm_gated_rst_b ( hqm_gated_rst_b )
    , .req             ( sch_dir_req )
    , .update          ( cls_taken[CHP_SCH_DIR] )
    , .winner_v        ( cls_v[CHP_SCH_DIR] )
    , .qid             ( sch_dir_qid )
  );

  chp_class_arb i_enq_ldb_arb (
      .hqm_gated_clk   ( hqm_gated_clk )
    , .hqm_gated_rst_b ( hqm_gated_rst_b )
    , .req             ( enq_ldb_req )
    , .update          ( cls_taken[CHP_ENQ_LDB] )
    , .winner_v        ( cls_v[CHP_ENQ_LDB] )
    , .qid             ( enq_ldb_qid )
  );

  // --------------------------------------------------
  // class selection and issue slots
  // --------------------------------------------------

  // qid ports follow the class slot order of chp_class_e
  chp_issue_sel i_issue_sel (
      .hqm_gated_clk   ( hqm_gated_clk )
    , .hqm_gated_rst_b ( hqm_gated_rst_b )
    , .cls_v           ( cls_v )
    , .cls_qid0        ( sch_ldb_qid )
    , .cls_qid1        ( enq_dir_qid )
    , .cls_qid2        ( sch_dir_qid )
    , .cls_qid3        ( enq_ldb_qid )
    , .hold            ( hold )
    , .cls_taken       ( cls_taken )
    , .issue0_v        ( issue0_v )
    , .issue0_class    ( issue0_class )
    , .issue0_qid      ( issue0_qid )
    , .issue1_v        ( issue1_v )
    , .issue1_class    ( issue1_class )
    , .issue1_qid      ( issue1_qid )
  );

endmodule

/* chp_pkg.sv */
/*
  Class encoding and set pairing for the issue arbiter.
  The slot order is fixed and the request vectors are wired in that order.
  Set A is {sch_ldb, enq_dir}, set B is {sch_dir, enq_ldb}.
*/

package chp_pkg;

  // slot index of each request class on the issue arbiter
  typedef enum logic [1:0] {
    CHP_SCH_LDB = 2'd0,
    CHP_ENQ_DIR = 2'd1,
    CHP_SCH_DIR = 2'd2,
    CHP_ENQ_LDB = 2'd3
  } chp_class_e;

  // the two resource sets, the members of a set never share hardware downstream
  typedef enum logic {
    CHP_SET_A = 1'b0,
    CHP_SET_B = 1'b1
  } chp_set_e;

  // the upper class bit selects the set
  function automatic chp_set_e set_of(input chp_class_e cls);
    return chp_set_e'(cls[1]);
  endfunction

  // partner is the other member of the same set, so 0 and 1 swap, 2 and 3 swap
  function automatic chp_class_e partner_of(input chp_class_e cls);
    return chp_class_e'({cls[1], ~cls[0]});
  endfunction

endpackage

/* chp_rr_arb_windex.sv */
/*
  Combinational round-robin arbiter with an externally held start index.
  The caller owns the index register and decides when it moves.
  NUM_REQS must be 2 or more. An index_f past NUM_REQS-1 wraps modulo NUM_REQS.
  winner reads zero when no request is set.
*/

`timescale 1ns/1ps

module chp_rr_arb_windex #(
  parameter int NUM_REQS = 4
) (
    input  logic [NUM_REQS-1:0]         reqs
  , input  logic [$clog2(NUM_REQS)-1:0] index_f
  , output logic                        winner_v
  , output logic [$clog2(NUM_REQS)-1:0] winner
);

  localparam int IDX_W = $clog2(NUM_REQS);

  // --------------------------------------------------
  // grant search
  // --------------------------------------------------

  // any request at all gives a grant this cycle
  assign winner_v = |reqs;

  // walk upward from index_f and wrap, the first set request wins
  // slot index_f itself has the highest priority
  always_comb begin : l_search
    int  cand;
    logic found;

    found  = 1'b0;
    winner = '0;
    for (int i = 0; i < NUM_REQS; i++) begin
      // candidate slot for this step of the cyclic walk
      cand = (int'(index_f) + i) % NUM_REQS;
      if (!found && reqs[cand]) begin
        found  = 1'b1;
        winner = IDX_W'(cand);
      end
    end
  end

endmodule

/* tb_chp_issue.sv */
/*
  Testbench for the issue-arbitration front end.
  Vectors come from chp_issue_stim.txt, so run it from the project root.
  Each vector is driven on a rising edge and checked 10 ns before the next one.
  The first mismatch ends the run.
*/

`timescale 1ns/1ps

`include "chp_defines.svh"

module tb_chp_issue;

  localparam int CLK_PERIOD = 100;
  localparam int RST_CYCLES = 10;

  // --------------------------------------------------
  // vector columns, in file order
  // --------------------------------------------------
  localparam int NUM_COLS  = 12;
  localparam int C_RST_B   = 0;
  localparam int C_HOLD    = 1;
  localparam int C_SCH_LDB = 2;
  localparam int C_ENQ_DIR = 3;
  localparam int C_SCH_DIR = 4;
  localparam int C_ENQ_LDB = 5;
  localparam int C_I0_V    = 6;
  localparam int C_I0_CLS  = 7;
  localparam int C_I0_QID  = 8;
  localparam int C_I1_V    = 9;
  localparam int C_I1_CLS  = 10;
  localparam int C_I1_QID  = 11;

  logic                       hqm_gated_clk;
  logic                       hqm_gated_rst_b;
  logic [`CHP_NUM_QUEUES-1:0] sch_ldb_req;
  logic [`CHP_NUM_QUEUES-1:0] enq_dir_req;
  logic [`CHP_NUM_QUEUES-1:0] sch_dir_req;
  logic [`CHP_NUM_QUEUES-1:0] enq_ldb_req;
  logic                       hold;
  logic                       issue0_v;
  logic [1:0]                 issue0_class;
  logic [`CHP_QID_W-1:0]      issue0_qid;
  logic                       issue1_v;
  logic [1:0]                 issue1_class;
  logic [`CHP_QID_W-1:0]      issue1_qid;

  // all vector fields, NUM_COLS per line, flattened
  int vec_q [$];
  int num_vec   = 0;
  bit loaded    = 1'b0;

  chp_issue_top UUT (
      .hqm_gated_clk   ( hqm_gated_clk )
    , .hqm_gated_rst_b ( hqm_gated_rst_b )
    , .sch_ldb_req     ( sch_ldb_req )
    , .enq_dir_req     ( enq_dir_req )
    , .sch_dir_req     ( sch_dir_req )
    , .enq_ldb_req     ( enq_ldb_req )
    , .hold            ( hold )
    , .issue0_v        ( issue0_v )
    , .issue0_class    ( issue0_class )
    , .issue0_qid      ( issue0_qid )
    , .issue1_v        ( issue1_v )
    , .issue1_class    ( issue1_class )
    , .issue1_qid      ( issue1_qid )
  );

  initial begin
    hqm_gated_clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2);
      hqm_gated_clk = ~hqm_gated_clk;
    end
  end

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------

  // comment and blank lines are skipped, every other line must hold all columns
  task automatic load_vectors();
    int    fd;
    int    cnt;
    string line;
    int    f [NUM_COLS];
    fd = $fopen("chp_issue_stim.txt", "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file chp_issue_stim.txt");
      $display("** FAIL **");
      $fatal(1, "no stimulus");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 1 && line.getc(0) != "#") begin
        cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                      f[0], f[1], f[2], f[3], f[4], f[5],
                      f[6], f[7], f[8], f[9], f[10], f[11]);
        if (cnt != NUM_COLS) begin
          $display("malformed stimulus line: %s", line);
          $display("** FAIL **");
          $fatal(1, "bad stimulus");
        end
        for (int k = 0; k < NUM_COLS; k++) begin
          vec_q.push_back(f[k]);
        end
      end
    end
    $fclose(fd);
    num_vec = vec_q.size() / NUM_COLS;
    loaded  = 1'b1;
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
    if (got !== exp) begin
      $display("[FAIL] %0t %s expected %0h actual %0h", $time, name, exp, got);
      $display("** FAIL **");
      $fatal(1, "output mismatch");
    end
  endtask

  // inputs change right after the edge, so the DUT samples them on the next one
  task automatic apply_vector(input int v);
    logic [31:0] col [NUM_COLS];
    for (int k = 0; k < NUM_COLS; k++) begin
      col[k] = vec_q[v * NUM_COLS + k];
    end
    hqm_gated_rst_b <= col[C_RST_B][0];
    hold            <= col[C_HOLD][0];
    sch_ldb_req     <= col[C_SCH_LDB][`CHP_NUM_QUEUES-1:0];
    enq_dir_req     <= col[C_ENQ_DIR][`CHP_NUM_QUEUES-1:0];
    sch_dir_req     <= col[C_SCH_DIR][`CHP_NUM_QUEUES-1:0];
    enq_ldb_req     <= col[C_ENQ_LDB][`CHP_NUM_QUEUES-1:0];
  endtask

  task automatic check_vector(input int v);
    int b;
    b = v * NUM_COLS;
    check_value("issue0_v", vec_q[b + C_I0_V], 32'(issue0_v));
    check_value("issue0_class", vec_q[b + C_I0_CLS], 32'(issue0_class));
    check_value("issue0_qid", vec_q[b + C_I0_QID], 32'(issue0_qid));
    check_value("issue1_v", vec_q[b + C_I1_V], 32'(issue1_v));
    check_value("issue1_class", vec_q[b + C_I1_CLS], 32'(issue1_class));
    check_value("issue1_qid", vec_q[b + C_I1_QID], 32'(issue1_qid));
  endtask

  // --------------------------------------------------
  // main sequence and watchdog
  // --------------------------------------------------

  initial begin : l_main
    hqm_gated_rst_b = 1'b0;
    hold            = 1'b0;
    sch_ldb_req     = '0;
    enq_dir_req     = '0;
    sch_dir_req     = '0;
    enq_ldb_req     = '0;
    load_vectors();
    repeat (RST_CYCLES) @(posedge hqm_gated_clk);
    // the first vector line also releases reset
    for (int v = 0; v < num_vec; v++) begin
      apply_vector(v);
      #(CLK_PERIOD - 10);
      check_vector(v);
      @(posedge hqm_gated_clk);
    end
    if (num_vec > 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      $display("the stimulus file held no vector lines");
      $display("** FAIL **");
      $fatal(1, "no vectors");
    end
  end

  // limit is one cycle per vector plus margin for reset
  initial begin : l_watchdog
    wait (loaded);
    #((num_vec + 20) * CLK_PERIOD);
    $display("timeout, the run did not end within %0d cycles", num_vec + 20);
    $display("** FAIL **");
    $fatal(1, "watchdog expired");
  end

endmodule
